/* build.f */
hw/cam_switch_pkg.sv
hw/key_debounce.sv
hw/main_path_delay.sv
hw/minor_pixel_buffer.sv
hw/source_select.sv
hw/cam_switch_top.sv
verification/cam_switch_tb.sv

/* Makefile */
# Verilator build and run for the camera switch testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= cam_switch_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Verification passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "run passed" || \
		(echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/cam_switch_tb.sv */
`timescale 1ns/1ns

module cam_switch_tb;

    localparam int clk_period_c = 10;
    localparam int lat_c        = cam_switch_pkg::main_delay_c + 1;
    // small frame of vsync, blanking and 4 lines of 16 active pixels.
    localparam int vsync_len_c  = 2;
    localparam int v_pre_c      = 12;
    localparam int act_c        = 16;
    localparam int line_c       = 24;
    localparam int lines_c      = 4;
    localparam int v_post_c     = 4;
    localparam int frame_c      = v_pre_c + lines_c * line_c + v_post_c;
    localparam int n_pix_c      = act_c * lines_c;
    localparam int minor_lead_c = 3;   // minor runs ahead of main.
    localparam int key_at_c     = 20;  // key goes down at this frame position.
    localparam int n_steps_c    = 8;
    localparam int watchdog_ns_c = n_steps_c * frame_c * 2 * clk_period_c;

    typedef enum logic [1:0] {
        src_main,
        src_minor,
        src_white
    } src_e;

    typedef struct packed {
        logic [7:0] key_len;  // 0 means no press.
        logic       minor_on;
        src_e       src;      // source expected in this frame.
    } step_t;

    localparam step_t steps_c [n_steps_c] = '{
        '{8'd0,  1'b1, src_main},   // plain pass-through without a press.
        '{8'd8,  1'b1, src_main},   // bounce shorter than the debounce window.
        '{8'd40, 1'b0, src_main},   // long press takes effect next frame.
        '{8'd0,  1'b0, src_white},  // minor selected but silent.
        '{8'd0,  1'b1, src_minor},
        '{8'd40, 1'b1, src_minor},  // press to go back.
        '{8'd0,  1'b1, src_main},
        '{8'd0,  1'b0, src_main}
    };

    logic                        main_clk;
    logic                        rstn;
    cam_switch_pkg::video_word_t i_main_word;
    cam_switch_pkg::video_word_t i_minor_word;
    logic                        i_key;
    cam_switch_pkg::video_word_t o_word;

    cam_switch_pkg::video_word_t ref_q [$];
    int checks;
    int errors;

    cam_switch_top u_cam_switch_top (
        .main_clk     (main_clk),
        .rstn         (rstn),
        .i_main_word  (i_main_word),
        .i_minor_word (i_minor_word),
        .i_key        (i_key),
        .o_word       (o_word)
    );

    initial begin
        main_clk = 1'b0;
        forever #(clk_period_c / 2) main_clk = ~main_clk;
    end

    // timing and coordinates of one frame position with colour left at zero.
    function automatic cam_switch_pkg::video_word_t frame_timing(input int p);
        cam_switch_pkg::video_word_t w;
        int l;
        int c;
        w = '0;
        w.vsync = p < vsync_len_c;
        if (p >= v_pre_c && p < v_pre_c + lines_c * line_c) begin
            l = (p - v_pre_c) / line_c;
            c = (p - v_pre_c) % line_c;
            w.de    = c < act_c;
            w.hsync = (c == act_c + 2) || (c == act_c + 3);
            w.x     = cam_switch_pkg::coord_x_t'(c);
            w.y     = cam_switch_pkg::coord_y_t'(l);
        end
        return w;
    endfunction

    // only meaningful on active positions.
    function automatic int pix_index(input int p);
        return ((p - v_pre_c) / line_c) * act_c + (p - v_pre_c) % line_c;
    endfunction

    function automatic cam_switch_pkg::rgb_t exp_rgb(input src_e src, input logic de,
                                                     input cam_switch_pkg::rgb_t main_rgb,
                                                     input cam_switch_pkg::rgb_t minor_rgb);
        if (src == src_main) begin
            return main_rgb;
        end
        if (de && src == src_minor) begin
            return minor_rgb;  // k-th minor pixel of the frame.
        end
        return cam_switch_pkg::white_c;
    endfunction

    task automatic drive_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge main_clk);
            i_main_word  <= '0;
            i_minor_word <= '0;
            i_key        <= 1'b0;
            ref_q.push_back('0);
        end
    endtask

    task automatic run_frame(input int idx);
        cam_switch_pkg::rgb_t        main_pix [n_pix_c];
        cam_switch_pkg::rgb_t        minor_pix [n_pix_c];
        cam_switch_pkg::video_word_t mw;
        cam_switch_pkg::video_word_t nw;
        cam_switch_pkg::video_word_t ew;
        logic [31:0]                 rnd;
        logic                        next_on;
        src_e                        prev_src;
        src_e                        src;
        int                          q;
        int                          k;
        next_on  = (idx + 1 < n_steps_c) ? steps_c[idx+1].minor_on : 1'b0;
        prev_src = (idx > 0) ? steps_c[idx-1].src : src_main;
        for (int i = 0; i < n_pix_c; i++) begin
            rnd = $urandom;
            main_pix[i] = rnd[23:0];
            rnd = $urandom;
            minor_pix[i] = rnd[23:0];
        end
        for (int p = 0; p < frame_c; p++) begin
            mw = frame_timing(p);
            k  = mw.de ? pix_index(p) : 0;
            if (mw.de) begin
                mw.rgb = main_pix[k];
            end
            q = p + minor_lead_c;
            if (q < frame_c) begin
                nw = steps_c[idx].minor_on ? frame_timing(q) : '0;
                if (nw.de) begin
                    nw.rgb = minor_pix[pix_index(q)];
                end
            end else begin
                nw = next_on ? frame_timing(q - frame_c) : '0;  // next frame's vsync.
            end
            // older words keep the old source until the second vsync cycle.
            src = (p < vsync_len_c) ? prev_src : steps_c[idx].src;
            ew     = mw;
            ew.rgb = exp_rgb(src, mw.de, mw.rgb, minor_pix[k]);
            @(posedge main_clk);
            i_main_word  <= mw;
            i_minor_word <= nw;
            i_key        <= (p >= key_at_c) && (p < key_at_c + int'(steps_c[idx].key_len));
            ref_q.push_back(ew);
        end
    endtask

    task automatic check_word(input cam_switch_pkg::video_word_t exp_w);
        checks++;
        if ({o_word.hsync, o_word.vsync, o_word.de} !== {exp_w.hsync, exp_w.vsync, exp_w.de}) begin
            errors++;
            $display("Error: o_word hsync/vsync/de got %h expected %h at %0t",
                     {o_word.hsync, o_word.vsync, o_word.de},
                     {exp_w.hsync, exp_w.vsync, exp_w.de}, $time);
        end
        if ({o_word.x, o_word.y} !== {exp_w.x, exp_w.y}) begin
            errors++;
            $display("Error: o_word x/y got %h/%h expected %h/%h at %0t",
                     o_word.x, o_word.y, exp_w.x, exp_w.y, $time);
        end
        if (o_word.rgb !== exp_w.rgb) begin
            errors++;
            $display("Error: o_word.rgb got %h expected %h at %0t", o_word.rgb, exp_w.rgb, $time);
        end
    endtask

    // outputs are compared away from the driving edge.
    always @(negedge main_clk) begin
        cam_switch_pkg::video_word_t exp_w;
        if (!rstn) begin
            checks++;
            if (o_word !== '0) begin
                errors++;
                $display("Error: o_word in reset got %h expected %h", o_word, 48'h0);
            end
        end else begin
            while (ref_q.size() > lat_c) begin
                exp_w = ref_q.pop_front();
                check_word(exp_w);
            end
        end
    end

    initial begin
        #(watchdog_ns_c);
        $display("run timed out after %0d ns before the scenario table finished", watchdog_ns_c);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hf162_5943));
        checks = 0;
        errors = 0;
        rstn         <= 1'b0;
        i_main_word  <= '0;
        i_minor_word <= '0;
        i_key        <= 1'b0;
        repeat (5) @(posedge main_clk);
        rstn <= 1'b1;
        drive_idle(4);
        for (int i = 0; i < n_steps_c; i++) begin
            run_frame(i);
        end
        drive_idle(lat_c + 2);  // flush the last frame through the pipe.
        @(posedge main_clk);
        if (checks < n_steps_c * frame_c) begin
            errors++;
            $display("fewer output words were compared than the frames drove");
        end
        $display("checked %0d words, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* hw/cam_switch_top.sv */
`timescale 1ns/1ns

module cam_switch_top (
    input  logic                        main_clk,
    input  logic                        rstn,
    input  cam_switch_pkg::video_word_t i_main_word,
    input  cam_switch_pkg::video_word_t i_minor_word,
    input  logic                        i_key,
    output cam_switch_pkg::video_word_t o_word
);

    logic                        press;
    cam_switch_pkg::video_word_t main_dly_word;
    logic                        early_de;
    logic                        early_vsync;
    logic                        hold;
    cam_switch_pkg::rgb_t        minor_rgb;

    key_debounce u_key_debounce (
        .main_clk (main_clk),
        .rstn     (rstn),
        .i_key    (i_key),
        .o_press  (press)
    );

    main_path_delay u_main_path_delay (
        .main_clk      (main_clk),
        .rstn          (rstn),
        .i_word        (i_main_word),
        .o_word        (main_dly_word),
        .o_early_de    (early_de),
        .o_early_vsync (early_vsync)
    );

    // read side follows main timing one stage early.
    minor_pixel_buffer u_minor_pixel_buffer (
        .main_clk     (main_clk),
        .rstn         (rstn),
        .i_hold       (hold),
        .i_minor_word (i_minor_word),
        .i_rd_en      (early_de),
        .i_rd_clear   (early_vsync),
        .o_rgb        (minor_rgb)
    );

    source_select u_source_select (
        .main_clk    (main_clk),
        .rstn        (rstn),
        .i_press     (press),
        .i_main_word (main_dly_word),
        .i_minor_rgb (minor_rgb),
        .o_hold      (hold),
        .o_word      (o_word)
    );

endmodule

/* hw/source_select.sv */
`timescale 1ns/1ns

module source_select (
    input  logic                        main_clk,
    input  logic                        rstn,
    input  logic                        i_press,
    input  cam_switch_pkg::video_word_t i_main_word,
    input  cam_switch_pkg::rgb_t        i_minor_rgb,
    output logic                        o_hold,
    output cam_switch_pkg::video_word_t o_word
);

    cam_switch_pkg::cam_sel_e sel_q;
    logic pending_q;  // press seen, waiting for frame start.
    logic vsync_d_q;
    logic apply;

    // second vsync cycle marks a clean frame boundary.
    assign apply = pending_q && vsync_d_q && i_main_word.vsync;

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            vsync_d_q <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            vsync_d_q <= i_main_word.vsync;
            pending_q <= (pending_q && !apply) || i_press;
        end
    end

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            sel_q <= cam_switch_pkg::cam_main;
        end else if (apply) begin
            sel_q <= (sel_q == cam_switch_pkg::cam_main) ? cam_switch_pkg::cam_minor
                                                         : cam_switch_pkg::cam_main;
        end
    end

    // buffer sits empty while the minor colour is unused.
    assign o_hold = sel_q == cam_switch_pkg::cam_main;

    // timing and coordinates always from main.
    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            o_word <= '0;
        end else begin
            o_word.hsync <= i_main_word.hsync;
            o_word.vsync <= i_main_word.vsync;
            o_word.de    <= i_main_word.de;
            o_word.x     <= i_main_word.x;
            o_word.y     <= i_main_word.y;
            if (sel_q == cam_switch_pkg::cam_minor) begin
                o_word.rgb <= i_minor_rgb;
            end else begin
                o_word.rgb <= i_main_word.rgb;
            end
        end
    end

endmodule

/* hw/minor_pixel_buffer.sv */
`timescale 1ns/1ns

module minor_pixel_buffer (
    input  logic                        main_clk,
    input  logic                        rstn,
    input  logic                        i_hold,
    input  cam_switch_pkg::video_word_t i_minor_word,
    input  logic                        i_rd_en,
    input  logic                        i_rd_clear,
    output cam_switch_pkg::rgb_t        o_rgb
);

    cam_switch_pkg::rgb_t mem [cam_switch_pkg::buf_depth_c];

    cam_switch_pkg::buf_addr_t wr_ptr_q;
    cam_switch_pkg::buf_addr_t rd_ptr_q;
    logic [$clog2(cam_switch_pkg::buf_depth_c):0] count_q;  // one extra bit for full.

    logic full;
    logic empty;
    logic wr_clear;
    logic wr_fire;
    logic rd_fire;

    assign full     = count_q == cam_switch_pkg::buf_depth_c;
    assign empty    = count_q == '0;
    assign wr_clear = i_minor_word.vsync;

    // clears win over data, hold blocks everything.
    assign wr_fire = i_minor_word.de && !wr_clear && !i_hold && !full;
    assign rd_fire = i_rd_en && !i_rd_clear && !i_hold && !empty;

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr_q <= '0;
        end else if (i_hold || wr_clear) begin
            wr_ptr_q <= '0;
        end else if (wr_fire) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr_q <= '0;
        end else if (i_hold || i_rd_clear) begin
            rd_ptr_q <= '0;
        end else if (rd_fire) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            count_q <= '0;
        end else if (i_hold || wr_clear) begin
            count_q <= '0;
        end else if (i_rd_clear) begin
            // read side restarts at address 0.
            // what the minor frame already wrote is all valid.
            count_q <= {1'b0, wr_ptr_q} + wr_fire;
        end else begin
            count_q <= count_q + wr_fire - rd_fire;
        end
    end

    always_ff @(posedge main_clk) begin
        if (wr_fire) begin
            mem[wr_ptr_q] <= i_minor_word.rgb;
        end
    end

    // white on empty reads and between reads.
    always_ff @(posedge main_clk) begin
        o_rgb <= rd_fire ? mem[rd_ptr_q] : cam_switch_pkg::white_c;
    end

endmodule

/* hw/main_path_delay.sv */
`timescale 1ns/1ns

module main_path_delay (
    input  logic                       main_clk,
    input  logic                       rstn,
    input  cam_switch_pkg::video_word_t i_word,
    output cam_switch_pkg::video_word_t o_word,
    output logic                       o_early_de,
    output logic                       o_early_vsync
);

    cam_switch_pkg::video_word_t stage_q [cam_switch_pkg::main_delay_c];

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < cam_switch_pkg::main_delay_c; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= i_word;
            for (int i = 1; i < cam_switch_pkg::main_delay_c; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign o_word = stage_q[cam_switch_pkg::main_delay_c-1];

    // tap one stage early so the buffer read lands with the last stage.
    assign o_early_de    = stage_q[cam_switch_pkg::main_delay_c-2].de;
    assign o_early_vsync = stage_q[cam_switch_pkg::main_delay_c-2].vsync;

endmodule

/* hw/key_debounce.sv */
`timescale 1ns/1ns

module key_debounce (
    input  logic main_clk,
    input  logic rstn,
    input  logic i_key,
    output logic o_press
);

    logic [1:0] key_sync_q;  // two-flop synchroniser.
    logic       key_level_q; // accepted level.
    logic [$clog2(cam_switch_pkg::debounce_cycles_c)-1:0] stable_cnt_q;
    logic       key_s;
    logic       level_diff;
    logic       accept;

    assign key_s      = key_sync_q[1];
    assign level_diff = key_s != key_level_q;
    assign accept     = level_diff
                        && (stable_cnt_q == cam_switch_pkg::debounce_cycles_c - 1);

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            key_sync_q <= '0;
        end else begin
            key_sync_q <= {key_sync_q[0], i_key};
        end
    end

    // counts cycles the synced key differs from the accepted level.
    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            stable_cnt_q <= '0;
            key_level_q  <= 1'b0;
        end else if (!level_diff || accept) begin
            stable_cnt_q <= '0; // bounce or accepted, start over.
            if (accept) begin
                key_level_q <= key_s;
            end
        end else begin
            stable_cnt_q <= stable_cnt_q + 1'b1;
        end
    end

    // one pulse per accepted press, releases give none.
    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            o_press <= 1'b0;
        end else begin
            o_press <= accept && key_s;
        end
    end

endmodule

/* hw/cam_switch_pkg.sv */
package cam_switch_pkg;

    // active frame size.
    localparam int h_act_c = 1280;
    localparam int v_act_c = 720;

    typedef logic [$clog2(h_act_c)-1:0] coord_x_t;  // 11 bits.
    typedef logic [$clog2(v_act_c)-1:0] coord_y_t;  // 10 bits.
    typedef logic [7:0]                 color_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    // word carried on every video port, 48 bits.
    typedef struct packed {
        logic     hsync;
        logic     vsync;
        logic     de;
        rgb_t     rgb;
        coord_x_t x;
        coord_y_t y;
    } video_word_t;

    localparam int main_delay_c = 5;  // main path latency before the mux.

    // one active line fits.
    localparam int buf_depth_c = 2048;
    typedef logic [$clog2(buf_depth_c)-1:0] buf_addr_t;

    localparam int debounce_cycles_c = 16;

    localparam rgb_t white_c = '1;  // shown when the buffer runs dry.

    typedef enum logic {
        cam_main,
        cam_minor
    } cam_sel_e;

endpackage
